/* rtl/snow64_cpu_pkg.sv */
package snow64_cpu_pkg;

	// instruction address width, pc counts words
	localparam int addr_width = 16;

	// register file and io data width
	localparam int data_width = 64;

	// one instruction word per memory read
	localparam int mem_data_width = 32;

	// memory read port, input side
	// used by fetch so it never sees io signals
	typedef struct packed {
		logic mem_ack;
		logic [mem_data_width-1:0] mem_rdata;
	} mem_if_in;

	// memory read port, output side
	typedef struct packed {
		logic mem_req;
		logic [addr_width-1:0] mem_addr;
	} mem_if_out;

	// everything entering the core
	typedef struct packed {
		logic mem_ack;
		logic [mem_data_width-1:0] mem_rdata;
		// io write ack from the sink
		logic io_ack;
	} port_in_cpu;

	// everything leaving the core
	typedef struct packed {
		logic mem_req;
		logic [addr_width-1:0] mem_addr;
		// io write request, data held while req is up
		logic io_req;
		logic [data_width-1:0] io_data;
		// sticky once halt retires
		logic halted;
	} port_out_cpu;

endpackage

/* rtl/snow64_instr_pkg.sv */
package snow64_instr_pkg;

	// instruction word is exactly one memory read word
	localparam int instr_width = snow64_cpu_pkg::mem_data_width;
	localparam int opcode_width = 4;
	localparam int reg_idx_width = 3;
	localparam int num_regs = 8;
	localparam int imm_width = 16;

	// opcode encodings, unlisted values decode as nop
	typedef enum logic [opcode_width-1:0] {
		op_nop = 4'd0,
		op_add = 4'd1,
		op_sub = 4'd2,
		op_and = 4'd3,
		op_or = 4'd4,
		op_xor = 4'd5,
		op_ldi = 4'd6,
		op_out = 4'd7,
		op_halt = 4'd15
	} opcode_e;

	// raw word layout, msb first
	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_idx_width-1:0] ra;
		logic [reg_idx_width-1:0] rb;
		logic [reg_idx_width-1:0] rc;
		logic [instr_width-opcode_width-3*reg_idx_width-imm_width-1:0] rsvd;
		logic [imm_width-1:0] imm16;
	} instr_word_t;

	// what travels down the pipeline
	typedef struct packed {
		opcode_e op;
		logic [reg_idx_width-1:0] ra;
		logic [reg_idx_width-1:0] rb;
		logic [reg_idx_width-1:0] rc;
		logic [snow64_cpu_pkg::data_width-1:0] imm;
		logic writes_reg;
		logic valid;
	} decoded_instr_t;

endpackage

/* rtl/snow64_instr_fetch.sv */
`timescale 1ns/1ps

module snow64_instr_fetch(
	input logic clk,
	input logic arst_n,
	input snow64_cpu_pkg::mem_if_in mem_in,
	output snow64_cpu_pkg::mem_if_out mem_out,
	input logic take,
	input logic stop,
	output logic instr_valid,
	output logic [snow64_instr_pkg::instr_width-1:0] instr
);
	import snow64_cpu_pkg::*;

	// idle -> req -> ack low -> hold, hold goes back to req on take
	typedef enum logic [1:0] {
		fetch_idle,
		fetch_req,
		fetch_ack_low,
		fetch_hold
	} fetch_state_e;

	fetch_state_e state;
	logic [addr_width-1:0] pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= fetch_idle;
			pc <= '0;
		end else begin
			case (state)
				fetch_idle: begin
					// only leaves idle while not halted
					if (!stop) begin
						state <= fetch_req;
					end
				end
				fetch_req: begin
					if (mem_in.mem_ack) begin
						state <= fetch_ack_low;
					end
				end
				fetch_ack_low: begin
					// four-phase, memory must drop ack first
					if (!mem_in.mem_ack) begin
						state <= fetch_hold;
					end
				end
				fetch_hold: begin
					// word consumed, move on to the next address
					if (take) begin
						pc <= pc + 1'b1;
						state <= stop ? fetch_idle : fetch_req;
					end
				end
				default: begin
					state <= fetch_idle;
				end
			endcase
		end
	end

	// word buffer, loaded on the ack cycle
	always_ff @(posedge clk) begin
		if (state == fetch_req && mem_in.mem_ack) begin
			instr <= mem_in.mem_rdata;
		end
	end

	// req tracks the state, addr stays put for the whole handshake
	assign mem_out.mem_req = (state == fetch_req);
	assign mem_out.mem_addr = pc;

	// at most one buffered word
	assign instr_valid = (state == fetch_hold);

endmodule

/* rtl/snow64_instr_decoder.sv */
`timescale 1ns/1ps

module snow64_instr_decoder(
	input logic instr_valid,
	input logic [snow64_instr_pkg::instr_width-1:0] instr,
	output snow64_instr_pkg::decoded_instr_t decoded
);
	import snow64_cpu_pkg::*;
	import snow64_instr_pkg::*;

	instr_word_t word;

	// view the raw bits through the field layout
	assign word = instr;

	always_comb begin
		// default is a nop that writes nothing
		decoded = '0;
		decoded.valid = instr_valid;
		decoded.ra = word.ra;
		decoded.rb = word.rb;
		decoded.rc = word.rc;
		// sign extend imm16 to full data width
		decoded.imm = {{(data_width - imm_width){word.imm16[imm_width-1]}}, word.imm16};

		case (opcode_e'(word.opcode))
			// alu ops and ldi write ra
			op_add, op_sub, op_and, op_or, op_xor, op_ldi: begin
				decoded.op = opcode_e'(word.opcode);
				decoded.writes_reg = 1'b1;
			end
			// out and halt pass through, no register write
			op_out, op_halt: begin
				decoded.op = opcode_e'(word.opcode);
			end
			// unknown encodings become nops
			default: begin
				decoded.op = op_nop;
			end
		endcase
	end

endmodule

/* rtl/snow64_reg_file.sv */
`timescale 1ns/1ps

module snow64_reg_file(
	input logic clk,
	input logic arst_n,
	input logic [snow64_instr_pkg::reg_idx_width-1:0] rd_idx_b,
	input logic [snow64_instr_pkg::reg_idx_width-1:0] rd_idx_c,
	output logic [snow64_cpu_pkg::data_width-1:0] rd_data_b,
	output logic [snow64_cpu_pkg::data_width-1:0] rd_data_c,
	input logic wr_en,
	input logic [snow64_instr_pkg::reg_idx_width-1:0] wr_idx,
	input logic [snow64_cpu_pkg::data_width-1:0] wr_data
);
	import snow64_cpu_pkg::*;
	import snow64_instr_pkg::*;

	// r0 is a normal register, no hardwired zero
	logic [data_width-1:0] regs [num_regs];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// all registers start at zero
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// async reads, a same-cycle write shows up next cycle
	// the forwarder covers that case
	assign rd_data_b = regs[rd_idx_b];
	assign rd_data_c = regs[rd_idx_c];

endmodule

/* rtl/snow64_operand_forward.sv */
`timescale 1ns/1ps

module snow64_operand_forward(
	input snow64_instr_pkg::decoded_instr_t decoded,
	input snow64_instr_pkg::decoded_instr_t ex_instr,
	input logic [snow64_cpu_pkg::data_width-1:0] ex_result,
	input snow64_instr_pkg::decoded_instr_t wb_instr,
	input logic [snow64_cpu_pkg::data_width-1:0] wb_result,
	input logic [snow64_cpu_pkg::data_width-1:0] file_b,
	input logic [snow64_cpu_pkg::data_width-1:0] file_c,
	output logic [snow64_cpu_pkg::data_width-1:0] opnd_b,
	output logic [snow64_cpu_pkg::data_width-1:0] opnd_c
);
	import snow64_instr_pkg::*;

	// stage is a usable source for idx
	function automatic logic fwd_hit(
		input decoded_instr_t src,
		input logic [reg_idx_width-1:0] idx
	);
		return src.valid && src.writes_reg && (src.ra == idx);
	endfunction

	// newest value wins, execute before write-back before file
	always_comb begin
		if (fwd_hit(ex_instr, decoded.rb)) begin
			opnd_b = ex_result;
		end else if (fwd_hit(wb_instr, decoded.rb)) begin
			opnd_b = wb_result;
		end else begin
			opnd_b = file_b;
		end
	end

	// same rule, second operand on its own
	always_comb begin
		if (fwd_hit(ex_instr, decoded.rc)) begin
			opnd_c = ex_result;
		end else if (fwd_hit(wb_instr, decoded.rc)) begin
			opnd_c = wb_result;
		end else begin
			opnd_c = file_c;
		end
	end

endmodule

/* rtl/snow64_execute.sv */
`timescale 1ns/1ps

module snow64_execute(
	input snow64_instr_pkg::decoded_instr_t instr,
	input logic [snow64_cpu_pkg::data_width-1:0] opnd_b,
	input logic [snow64_cpu_pkg::data_width-1:0] opnd_c,
	output logic [snow64_cpu_pkg::data_width-1:0] result
);
	import snow64_instr_pkg::*;

	// single-cycle alu
	// add and sub wrap mod 2^64, no flags kept
	always_comb begin
		case (instr.op)
			op_add: begin
				result = opnd_b + opnd_c;
			end
			op_sub: begin
				result = opnd_b - opnd_c;
			end
			op_and: begin
				result = opnd_b & opnd_c;
			end
			op_or: begin
				result = opnd_b | opnd_c;
			end
			op_xor: begin
				result = opnd_b ^ opnd_c;
			end
			// immediate already sign extended by decode
			op_ldi: begin
				result = instr.imm;
			end
			// value for the io port rides in the result slot
			op_out: begin
				result = opnd_b;
			end
			// nop, halt
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* rtl/snow64_cpu.sv */
`timescale 1ns/1ps

module snow64_cpu(
	input logic clk,
	input logic arst_n,
	input snow64_cpu_pkg::port_in_cpu in,
	output snow64_cpu_pkg::port_out_cpu out
);
	import snow64_cpu_pkg::*;
	import snow64_instr_pkg::*;

	// io write master, four-phase
	typedef enum logic [1:0] {
		io_idle,
		io_req_high,
		io_ack_low
	} io_state_e;

	mem_if_in mem_in;
	mem_if_out mem_out;
	logic instr_valid;
	logic [instr_width-1:0] instr;
	logic take;
	logic advance;
	logic halted;
	decoded_instr_t dec_instr;
	decoded_instr_t ex_instr;
	decoded_instr_t wb_instr;
	logic [data_width-1:0] file_b;
	logic [data_width-1:0] file_c;
	logic [data_width-1:0] opnd_b;
	logic [data_width-1:0] opnd_c;
	logic [data_width-1:0] ex_opnd_b;
	logic [data_width-1:0] ex_opnd_c;
	logic [data_width-1:0] ex_result;
	logic [data_width-1:0] wb_result;
	io_state_e io_state;
	logic wb_is_out;
	logic io_done;

	// port unpack
	assign mem_in.mem_ack = in.mem_ack;
	assign mem_in.mem_rdata = in.mem_rdata;

	// port pack
	assign out.mem_req = mem_out.mem_req;
	assign out.mem_addr = mem_out.mem_addr;
	assign out.io_req = (io_state == io_req_high);
	// wb_result is frozen while the handshake stalls the pipe
	assign out.io_data = wb_result;
	assign out.halted = halted;

	// out in write-back holds everything until ack drops again
	assign wb_is_out = wb_instr.valid && (wb_instr.op == op_out);
	assign io_done = (io_state == io_ack_low) && !in.io_ack;
	assign advance = !halted && (!wb_is_out || io_done);
	// decode consumes the fetched word only on an advancing cycle
	assign take = advance && instr_valid;

	snow64_instr_fetch i_fetch(
		.clk(clk),
		.arst_n(arst_n),
		.mem_in(mem_in),
		.mem_out(mem_out),
		.take(take),
		.stop(halted),
		.instr_valid(instr_valid),
		.instr(instr)
	);

	// decode stage, bubble when fetch has nothing
	snow64_instr_decoder i_decoder(
		.instr_valid(instr_valid),
		.instr(instr),
		.decoded(dec_instr)
	);

	// written from write-back on the advancing edge
	snow64_reg_file i_reg_file(
		.clk(clk),
		.arst_n(arst_n),
		.rd_idx_b(dec_instr.rb),
		.rd_idx_c(dec_instr.rc),
		.rd_data_b(file_b),
		.rd_data_c(file_c),
		.wr_en(advance && wb_instr.valid && wb_instr.writes_reg),
		.wr_idx(wb_instr.ra),
		.wr_data(wb_result)
	);

	snow64_operand_forward i_forward(
		.decoded(dec_instr),
		.ex_instr(ex_instr),
		.ex_result(ex_result),
		.wb_instr(wb_instr),
		.wb_result(wb_result),
		.file_b(file_b),
		.file_c(file_c),
		.opnd_b(opnd_b),
		.opnd_c(opnd_c)
	);

	snow64_execute i_execute(
		.instr(ex_instr),
		.opnd_b(ex_opnd_b),
		.opnd_c(ex_opnd_c),
		.result(ex_result)
	);

	// stage control and sticky halt
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_instr <= '0;
			wb_instr <= '0;
			halted <= 1'b0;
		end else if (advance) begin
			ex_instr <= dec_instr;
			wb_instr <= ex_instr;
			// halt raises the flag as it enters write-back
			// nothing behind it retires after that
			if (ex_instr.valid && ex_instr.op == op_halt) begin
				halted <= 1'b1;
			end
		end
	end

	// operand and result payload
	always_ff @(posedge clk) begin
		if (advance) begin
			ex_opnd_b <= opnd_b;
			ex_opnd_c <= opnd_c;
			wb_result <= ex_result;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			io_state <= io_idle;
		end else begin
			case (io_state)
				io_idle: begin
					if (wb_is_out) begin
						io_state <= io_req_high;
					end
				end
				io_req_high: begin
					if (in.io_ack) begin
						io_state <= io_ack_low;
					end
				end
				// retire happens on the cycle ack is seen low
				io_ack_low: begin
					if (!in.io_ack) begin
						io_state <= io_idle;
					end
				end
				default: begin
					io_state <= io_idle;
				end
			endcase
		end
	end

endmodule

/* test/snow64_mem_model.sv */
`timescale 1ns/1ps

module snow64_mem_model(
	input logic clk,
	input logic arst_n,
	input logic [15:0][snow64_instr_pkg::instr_width-1:0] prog,
	input logic mem_req,
	input logic [snow64_cpu_pkg::addr_width-1:0] mem_addr,
	output logic mem_ack,
	output logic [snow64_instr_pkg::instr_width-1:0] mem_rdata
);
	import snow64_cpu_pkg::*;
	import snow64_instr_pkg::*;

	// answer side of the four-phase read
	typedef enum logic [1:0] {
		mem_idle,
		mem_delay,
		mem_acked
	} mem_state_e;

	mem_state_e state;
	logic [31:0] rnd;
	int delay;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// program words first, then nops tagged with their address
	function automatic logic [instr_width-1:0] word_at(input logic [addr_width-1:0] addr);
		if (addr < 16) begin
			return prog[addr[3:0]];
		end
		return {{(instr_width - addr_width){1'b0}}, addr};
	endfunction

	// delay sequence runs on across resets
	initial begin
		rnd = 32'h69fe724a;
		mem_ack = 1'b0;
		mem_rdata = '0;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mem_idle;
			mem_ack <= 1'b0;
			delay <= 0;
		end else begin
			case (state)
				mem_idle: begin
					// 0 to 5 idle cycles before ack
					if (mem_req) begin
						rnd <= xorshift32(rnd);
						delay <= xorshift32(rnd) % 6;
						state <= mem_delay;
					end
				end
				mem_delay: begin
					if (delay == 0) begin
						mem_ack <= 1'b1;
						mem_rdata <= word_at(mem_addr);
						state <= mem_acked;
					end else begin
						delay <= delay - 1;
					end
				end
				mem_acked: begin
					// ack drops only after req went low
					if (!mem_req) begin
						mem_ack <= 1'b0;
						state <= mem_idle;
					end
				end
				default: begin
					state <= mem_idle;
				end
			endcase
		end
	end

endmodule

/* test/snow64_cpu_tb.sv */
`timescale 1ns/1ps

module snow64_cpu_tb;
	import snow64_cpu_pkg::*;
	import snow64_instr_pkg::*;

	localparam int num_rows = 5;
	localparam int prog_depth = 16;
	localparam int quiet_cycles = 30;
	localparam logic [31:0] seed = 32'h69fe724a;

	// io sink, answer side of the four-phase write
	typedef enum logic [1:0] {
		sink_idle,
		sink_delay,
		sink_acked
	} sink_state_e;

	logic clk;
	logic arst_n;
	logic mem_ack;
	logic [instr_width-1:0] mem_rdata;
	logic io_ack;
	port_in_cpu cpu_in;
	port_out_cpu cpu_out;
	logic [prog_depth-1:0][instr_width-1:0] prog;

	// stimulus table, expected columns filled by the interpreter
	logic [prog_depth-1:0][instr_width-1:0] prog_table [num_rows];
	int prog_len [num_rows];
	logic [data_width-1:0] exp_vals [num_rows][prog_depth];
	int exp_count [num_rows];

	logic [data_width-1:0] received [$];
	sink_state_e sink_state;
	int sink_wait;
	logic [31:0] sink_rnd;

	int cycles;
	int cycle_limit;
	logic first_seen;
	logic [addr_width-1:0] first_addr;
	logic halted_q;
	logic req_q;
	int late_reqs;

	// packed msb first, same order as port_in_cpu
	assign cpu_in = {mem_ack, mem_rdata, io_ack};

	snow64_cpu i_dut(
		.clk(clk),
		.arst_n(arst_n),
		.in(cpu_in),
		.out(cpu_out)
	);

	snow64_mem_model i_mem(
		.clk(clk),
		.arst_n(arst_n),
		.prog(prog),
		.mem_req(cpu_out.mem_req),
		.mem_addr(cpu_out.mem_addr),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// instruction encoders, layout op ra rb rc rsvd imm16
	function automatic logic [instr_width-1:0] enc_alu(input opcode_e op,
			input logic [2:0] ra, input logic [2:0] rb, input logic [2:0] rc);
		return {op, ra, rb, rc, 3'b000, 16'h0000};
	endfunction

	function automatic logic [instr_width-1:0] enc_ldi(input logic [2:0] ra,
			input logic [15:0] imm);
		return {op_ldi, ra, 9'd0, imm};
	endfunction

	function automatic logic [instr_width-1:0] enc_out(input logic [2:0] rb);
		return {op_out, 3'd0, rb, 22'd0};
	endfunction

	function automatic logic [instr_width-1:0] enc_halt();
		return {op_halt, 28'd0};
	endfunction

	task automatic append_word(input int r, input logic [instr_width-1:0] word);
		prog_table[r][prog_len[r]] = word;
		prog_len[r]++;
	endtask

	// sequential reference, one instruction at a time, stops at halt
	task automatic interpret(input int r);
		logic [data_width-1:0] regs [num_regs];
		logic [instr_width-1:0] w;
		logic [data_width-1:0] b;
		logic [data_width-1:0] c;
		int n;
		logic done;
		for (int i = 0; i < num_regs; i++) begin
			regs[i] = '0;
		end
		n = 0;
		done = 1'b0;
		for (int pc = 0; pc < prog_depth && !done; pc++) begin
			w = prog_table[r][pc];
			b = regs[w[24:22]];
			c = regs[w[21:19]];
			case (w[31:28])
				op_add: regs[w[27:25]] = b + c;
				op_sub: regs[w[27:25]] = b - c;
				op_and: regs[w[27:25]] = b & c;
				op_or: regs[w[27:25]] = b | c;
				op_xor: regs[w[27:25]] = b ^ c;
				op_ldi: regs[w[27:25]] = {{48{w[15]}}, w[15:0]};
				op_out: begin
					exp_vals[r][n] = b;
					n++;
				end
				op_halt: done = 1'b1;
				default: ;
			endcase
		end
		exp_count[r] = n;
	endtask

	task automatic build_table();
		int total;
		total = 0;
		for (int r = 0; r < num_rows; r++) begin
			prog_len[r] = 0;
			// padding is an address-tagged nop
			for (int i = 0; i < prog_depth; i++) begin
				prog_table[r][i] = {16'h0000, i[15:0]};
			end
		end
		// row 0, positive and negative immediates, out right after ldi
		append_word(0, enc_ldi(1, 16'h1234));
		append_word(0, enc_out(1));
		append_word(0, enc_ldi(2, 16'h8001));
		append_word(0, enc_out(2));
		append_word(0, enc_ldi(0, 16'hffff));
		append_word(0, enc_out(0));
		append_word(0, enc_halt());
		append_word(0, enc_out(1));
		// row 1, every alu op, sub wraps below zero
		append_word(1, enc_ldi(1, 16'h7f00));
		append_word(1, enc_ldi(2, 16'h00ff));
		append_word(1, enc_alu(op_add, 3, 1, 2));
		append_word(1, enc_alu(op_sub, 4, 2, 1));
		append_word(1, enc_alu(op_and, 5, 1, 2));
		append_word(1, enc_alu(op_or, 6, 1, 2));
		append_word(1, enc_alu(op_xor, 7, 4, 1));
		for (int k = 3; k < 8; k++) begin
			append_word(1, enc_out(k[2:0]));
		end
		append_word(1, enc_halt());
		// row 2, forwarding at distance one, two, three and mixed
		append_word(2, enc_ldi(1, 16'd5));
		append_word(2, enc_alu(op_add, 2, 1, 1));
		append_word(2, enc_ldi(3, 16'hfffe));
		append_word(2, enc_alu(op_xor, 0, 0, 0));
		append_word(2, enc_alu(op_add, 4, 3, 3));
		append_word(2, 32'h0000_0000);
		append_word(2, 32'h0000_0000);
		append_word(2, enc_alu(op_sub, 5, 4, 2));
		append_word(2, enc_alu(op_or, 6, 5, 4));
		append_word(2, enc_alu(op_add, 7, 6, 5));
		append_word(2, enc_out(7));
		append_word(2, enc_out(2));
		append_word(2, enc_out(5));
		append_word(2, enc_halt());
		append_word(2, enc_out(1));
		// row 3, back to back outs under random stalls
		append_word(3, enc_ldi(1, 16'd1));
		append_word(3, enc_out(1));
		append_word(3, enc_alu(op_add, 1, 1, 1));
		append_word(3, enc_out(1));
		append_word(3, enc_alu(op_add, 1, 1, 1));
		append_word(3, enc_out(1));
		// unknown opcode behaves as nop, its ra field names r1
		append_word(3, 32'h9323_4567);
		append_word(3, enc_out(1));
		append_word(3, enc_alu(op_sub, 2, 0, 1));
		append_word(3, enc_out(2));
		append_word(3, enc_alu(op_xor, 3, 2, 1));
		append_word(3, enc_out(3));
		append_word(3, enc_halt());
		// row 4, registers cleared by reset, nothing after halt
		append_word(4, enc_out(3));
		append_word(4, enc_ldi(2, 16'h0abc));
		append_word(4, enc_halt());
		append_word(4, enc_out(2));
		append_word(4, enc_out(2));
		append_word(4, enc_alu(op_add, 2, 2, 2));
		for (int r = 0; r < num_rows; r++) begin
			interpret(r);
			total += prog_len[r];
		end
		cycle_limit = 200 * total;
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [data_width-1:0] got,
			input logic [data_width-1:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			fail_run("a checked value was wrong");
		end
	endtask

	task automatic run_row(input int r);
		@(posedge clk);
		arst_n <= 1'b0;
		prog <= prog_table[r];
		repeat (4) @(posedge clk);
		received.delete();
		check_value(cpu_out.mem_req, 1'b0, "mem_req in reset");
		check_value(cpu_out.io_req, 1'b0, "io_req in reset");
		check_value(cpu_out.halted, 1'b0, "halted in reset");
		arst_n <= 1'b1;
		while (!cpu_out.halted) begin
			@(posedge clk);
		end
		// quiet window, nothing may move after halt
		repeat (quiet_cycles) @(posedge clk);
		check_value(first_addr, '0, $sformatf("row %0d first fetch address", r));
		check_value(late_reqs, 0, $sformatf("row %0d requests after halt", r));
		check_value(cpu_out.halted, 1'b1, $sformatf("row %0d halted held", r));
		check_value(received.size(), exp_count[r], $sformatf("row %0d output count", r));
		for (int k = 0; k < exp_count[r]; k++) begin
			check_value(received[k], exp_vals[r][k], $sformatf("row %0d output %0d", r, k));
		end
	endtask

	// io sink, 0 to 5 cycles before ack
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sink_state <= sink_idle;
			io_ack <= 1'b0;
			sink_wait <= 0;
		end else begin
			case (sink_state)
				sink_idle: begin
					if (cpu_out.io_req) begin
						sink_rnd <= xorshift32(sink_rnd);
						sink_wait <= xorshift32(sink_rnd) % 6;
						sink_state <= sink_delay;
					end
				end
				sink_delay: begin
					if (sink_wait == 0) begin
						io_ack <= 1'b1;
						received.push_back(cpu_out.io_data);
						sink_state <= sink_acked;
					end else begin
						sink_wait <= sink_wait - 1;
					end
				end
				sink_acked: begin
					if (!cpu_out.io_req) begin
						io_ack <= 1'b0;
						sink_state <= sink_idle;
					end
				end
				default: begin
					sink_state <= sink_idle;
				end
			endcase
		end
	end

	// first fetch address, new requests raised once halted
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			first_seen <= 1'b0;
			first_addr <= '1;
			halted_q <= 1'b0;
			req_q <= 1'b0;
			late_reqs <= 0;
		end else begin
			if (cpu_out.mem_req && !first_seen) begin
				first_seen <= 1'b1;
				first_addr <= cpu_out.mem_addr;
			end
			// an in-flight request may finish, a fresh rise may not
			if (halted_q && !req_q && cpu_out.mem_req) begin
				late_reqs <= late_reqs + 1;
			end
			halted_q <= cpu_out.halted;
			req_q <= cpu_out.mem_req;
		end
	end

	// run limit over all rows
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			fail_run("timeout: the core did not halt in time");
		end
	end

	initial begin
		arst_n = 1'b0;
		io_ack = 1'b0;
		prog = '0;
		sink_rnd = seed;
		cycles = 0;
		build_table();
		for (int r = 0; r < num_rows; r++) begin
			run_row(r);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* project.f */
rtl/snow64_cpu_pkg.sv
rtl/snow64_instr_pkg.sv
rtl/snow64_instr_fetch.sv
rtl/snow64_instr_decoder.sv
rtl/snow64_reg_file.sv
rtl/snow64_operand_forward.sv
rtl/snow64_execute.sv
rtl/snow64_cpu.sv
test/snow64_mem_model.sv
test/snow64_cpu_tb.sv

/* Bender.yml */
package:
  name: snow64_cpu

sources:
  # packages first, then the core from the leaves up
  - rtl/snow64_cpu_pkg.sv
  - rtl/snow64_instr_pkg.sv
  - rtl/snow64_instr_fetch.sv
  - rtl/snow64_instr_decoder.sv
  - rtl/snow64_reg_file.sv
  - rtl/snow64_operand_forward.sv
  - rtl/snow64_execute.sv
  - rtl/snow64_cpu.sv
  - target: test
    files:
      - test/snow64_mem_model.sv
      - test/snow64_cpu_tb.sv
